// File: common/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Bus and data widths
`define SPI_DATA_W        32
`define SPI_ADDR_W        8

// Subsystem sizing
`define SPI_NUM_PROFILES  4
`define SPI_NUM_DEVICES   4
`define SPI_CMD_DEPTH     4
`define SPI_MISO_DEPTH    8

// ID register value spelling "SPI!" in ASCII
`define SPI_MAGIC         32'h5350_4921

// Register word addresses
`define REG_ID            8'h00
`define REG_CTRL          8'h01
`define REG_CMPLCNT       8'h02
`define REG_INTRACK       8'h03
`define REG_DEVSEL        8'h10
`define REG_PROFSEL       8'h11
`define REG_CMDID         8'h12
`define REG_MOSI          8'h18
`define REG_MISO          8'h19
`define REG_TRIGGER       8'h1F
`define REG_PROFBASE      8'h20
`define REG_PROFSTRIDE    8

// Offsets inside one profile window
`define REG_PROF_POLPHA   0
`define REG_PROF_SCLKDIV  1
`define REG_PROF_XFERLEN  2
`define REG_PROF_GUARD    3

`endif

// File: common/spi_pkg.sv
`include "spi_settings.svh"

package spi_pkg;

    typedef logic [`SPI_DATA_W-1:0] word_t;

    // One timing profile as held in the register block
    typedef struct packed {
        logic       cpol;
        logic       cpha;
        logic [7:0] sclk_div;
        logic [5:0] xfer_len;
        logic [7:0] guard;
    } profile_t;

    // Self-contained command passed from the register block to the engine
    typedef struct packed {
        logic [15:0]                        id;
        logic [$clog2(`SPI_NUM_DEVICES)-1:0] device;
        logic                               cpol;
        logic                               cpha;
        logic [7:0]                         sclk_div;
        logic [5:0]                         xfer_len;
        logic [7:0]                         guard;
        word_t                              mosi;
    } cmd_t;

    typedef enum int {
        CTRL_ENABLE   = 0,
        CTRL_ERROR    = 1,
        CTRL_BUSY     = 2,
        CTRL_AUTOINC  = 3,
        CTRL_INTR     = 4,
        CTRL_INTR_EN  = 5
    } ctrl_bit_e;

endpackage

// File: design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     aximm,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge aximm) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aximm) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: spi_csr/spi_csr.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_csr import spi_pkg::*; (
    input  logic                   aximm,
    input  logic                   rst,
    input  logic                   reg_req,
    input  logic                   reg_we,
    input  logic [`SPI_ADDR_W-1:0] reg_addr,
    input  logic [`SPI_DATA_W-1:0] reg_wdata,
    output logic                   reg_ack,
    output logic [`SPI_DATA_W-1:0] reg_rdata,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output cmd_t                   cmd_data,
    input  logic                   miso_valid,
    output logic                   miso_ready,
    input  word_t                  miso_data,
    output logic                   enable,
    input  logic                   busy,
    input  logic                   done,
    output logic                   intr
);
    localparam int DEV_W  = $clog2(`SPI_NUM_DEVICES);
    localparam int PSEL_W = $clog2(`SPI_NUM_PROFILES);
    localparam int FLD_W  = $clog2(`REG_PROFSTRIDE);

    // Mode 0, slowest clock, one byte, longest guard
    localparam profile_t PROF_RESET = '{
        cpol: 1'b0, cpha: 1'b0, sclk_div: 8'hff, xfer_len: 6'd8, guard: 8'hff
    };

    profile_t               profiles [`SPI_NUM_PROFILES];
    logic [DEV_W-1:0]       dev_sel;
    logic [PSEL_W-1:0]      prof_sel;
    logic [15:0]            cmd_id;
    word_t                  mosi_word;
    word_t                  cmpl_cnt;
    logic                   autoinc;
    logic                   error;
    logic                   failed_issue;
    logic                   intr_en;
    logic                   intr_pend;

    logic                   access;
    logic                   wr;
    logic                   trigger;
    logic [`SPI_ADDR_W-1:0] prof_off;
    logic [PSEL_W-1:0]      prof_idx;
    logic [FLD_W-1:0]       prof_fld;
    logic                   prof_hit;
    profile_t               sel_prof;
    profile_t               rd_prof;
    word_t                  ctrl_rd;
    word_t                  rd_next;

    // An access is performed once, in the cycle before ack rises
    assign access   = reg_req && !reg_ack;
    assign wr       = access && reg_we;
    assign trigger  = wr && (reg_addr == `REG_TRIGGER);

    assign prof_off = reg_addr - `REG_PROFBASE;
    assign prof_idx = PSEL_W'(prof_off / `REG_PROFSTRIDE);
    assign prof_fld = FLD_W'(prof_off % `REG_PROFSTRIDE);
    assign prof_hit = (reg_addr >= `REG_PROFBASE) &&
                      (prof_off < `SPI_NUM_PROFILES * `REG_PROFSTRIDE);

    assign cmd_valid  = trigger;
    assign miso_ready = access && !reg_we && (reg_addr == `REG_MISO);
    assign intr       = intr_pend && intr_en;

    // Command built from the selected profile at trigger time
    always_comb begin
        sel_prof          = profiles[prof_sel];
        cmd_data.id       = cmd_id;
        cmd_data.device   = dev_sel;
        cmd_data.cpol     = sel_prof.cpol;
        cmd_data.cpha     = sel_prof.cpha;
        cmd_data.sclk_div = sel_prof.sclk_div;
        cmd_data.xfer_len = sel_prof.xfer_len;
        cmd_data.guard    = sel_prof.guard;
        cmd_data.mosi     = mosi_word;
    end

    always_ff @(posedge aximm) begin
        if (rst) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= reg_req;
        end
    end

    always_ff @(posedge aximm) begin
        if (access) begin
            reg_rdata <= rd_next;
        end
    end

    always_ff @(posedge aximm) begin
        if (rst) begin
            enable       <= 1'b0;
            autoinc      <= 1'b0;
            intr_en      <= 1'b0;
            error        <= 1'b0;
            failed_issue <= 1'b0;
            dev_sel      <= '0;
            prof_sel     <= '0;
            cmd_id       <= '0;
            mosi_word    <= '0;
        end else if (wr) begin
            case (reg_addr)
                `REG_CTRL: begin
                    enable  <= reg_wdata[CTRL_ENABLE];
                    autoinc <= reg_wdata[CTRL_AUTOINC];
                    intr_en <= reg_wdata[CTRL_INTR_EN];
                    if (reg_wdata[CTRL_ERROR]) begin
                        error        <= 1'b0;
                        failed_issue <= 1'b0;
                    end
                end
                `REG_DEVSEL:  dev_sel   <= reg_wdata[DEV_W-1:0];
                `REG_PROFSEL: prof_sel  <= reg_wdata[PSEL_W-1:0];
                `REG_CMDID:   cmd_id    <= reg_wdata[15:0];
                `REG_MOSI:    mosi_word <= reg_wdata;
                `REG_TRIGGER: begin
                    // Queue full means the command is lost
                    if (!cmd_ready) begin
                        error        <= 1'b1;
                        failed_issue <= 1'b1;
                    end else if (autoinc) begin
                        cmd_id <= cmd_id + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge aximm) begin
        if (rst) begin
            for (int i = 0; i < `SPI_NUM_PROFILES; i++) begin
                profiles[i] <= PROF_RESET;
            end
        end else if (wr && prof_hit) begin
            case (prof_fld)
                `REG_PROF_POLPHA: begin
                    profiles[prof_idx].cpol <= reg_wdata[1];
                    profiles[prof_idx].cpha <= reg_wdata[0];
                end
                `REG_PROF_SCLKDIV: profiles[prof_idx].sclk_div <= reg_wdata[7:0];
                `REG_PROF_XFERLEN: profiles[prof_idx].xfer_len <= reg_wdata[5:0];
                `REG_PROF_GUARD:   profiles[prof_idx].guard    <= reg_wdata[7:0];
                default: ;
            endcase
        end
    end

    // Ack write wins over a completion in the same cycle
    always_ff @(posedge aximm) begin
        if (rst) begin
            cmpl_cnt  <= '0;
            intr_pend <= 1'b0;
        end else begin
            cmpl_cnt <= ((wr && reg_addr == `REG_CMPLCNT) ? '0 : cmpl_cnt) + word_t'(done);
            if (wr && reg_addr == `REG_INTRACK) begin
                intr_pend <= 1'b0;
            end else if (done) begin
                intr_pend <= 1'b1;
            end
        end
    end

    always_comb begin
        ctrl_rd               = '0;
        ctrl_rd[CTRL_ENABLE]  = enable;
        ctrl_rd[CTRL_ERROR]   = error;
        ctrl_rd[CTRL_BUSY]    = busy;
        ctrl_rd[CTRL_AUTOINC] = autoinc;
        ctrl_rd[CTRL_INTR]    = intr_pend;
        ctrl_rd[CTRL_INTR_EN] = intr_en;
        rd_prof               = profiles[prof_idx];
        rd_next               = '0;
        if (prof_hit) begin
            case (prof_fld)
                `REG_PROF_POLPHA:  rd_next = word_t'({rd_prof.cpol, rd_prof.cpha});
                `REG_PROF_SCLKDIV: rd_next = word_t'(rd_prof.sclk_div);
                `REG_PROF_XFERLEN: rd_next = word_t'(rd_prof.xfer_len);
                `REG_PROF_GUARD:   rd_next = word_t'(rd_prof.guard);
                default:           rd_next = '0;
            endcase
        end else begin
            case (reg_addr)
                `REG_ID:      rd_next = `SPI_MAGIC;
                `REG_CTRL:    rd_next = ctrl_rd;
                `REG_CMPLCNT: rd_next = cmpl_cnt;
                `REG_DEVSEL:  rd_next = word_t'(dev_sel);
                `REG_PROFSEL: rd_next = word_t'(prof_sel);
                `REG_CMDID:   rd_next = word_t'(cmd_id);
                `REG_MOSI:    rd_next = mosi_word;
                `REG_MISO:    rd_next = miso_valid ? miso_data : '1;
                `REG_TRIGGER: rd_next = word_t'({failed_issue, cmd_ready});
                default:      rd_next = '0;
            endcase
        end
    end

endmodule

// File: spi_engine/spi_engine.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_engine import spi_pkg::*; (
    input  logic                        aximm,
    input  logic                        rst,
    input  logic                        enable,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  cmd_t                        cmd_data,
    output logic                        miso_valid,
    input  logic                        miso_ready,
    output word_t                       miso_data,
    output logic                        busy,
    output logic                        done,
    output logic [`SPI_NUM_DEVICES-1:0] csn,
    output logic                        sclk,
    output logic                        mosi,
    input  logic                        miso
);
    localparam int DW = `SPI_DATA_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LEAD,
        ST_SHIFT,
        ST_TRAIL,
        ST_DELIVER
    } state_e;

    state_e     state;
    cmd_t       cmd_q;
    logic [7:0] tick;
    logic [5:0] bits_left;
    logic       half;
    logic       cpol_q;
    word_t      tx_sh;
    word_t      rx_sh;
    logic       pop;
    logic       tick_end;
    logic       sample;
    logic       advance;

    assign cmd_ready  = enable && (state == ST_IDLE);
    assign pop        = cmd_valid && cmd_ready;
    assign busy       = state != ST_IDLE;
    assign miso_valid = state == ST_DELIVER;
    assign miso_data  = rx_sh;
    assign done       = miso_valid && miso_ready;
    assign tick_end   = tick == 8'd0;

    // Each bit is two halves; sample at the end of the first, shift at the end of the second
    assign sample  = (state == ST_SHIFT) && tick_end && !half;
    assign advance = (state == ST_SHIFT) && tick_end && half;

    // cpha flips the waveform so the sample point lands on the right edge
    assign sclk = (state == ST_SHIFT) ? (cpol_q ^ cmd_q.cpha ^ half) : cpol_q;
    assign mosi = (state == ST_SHIFT) ? tx_sh[DW-1] : 1'b0;

    always_comb begin
        csn = '1;
        if (state == ST_LEAD || state == ST_SHIFT || state == ST_TRAIL) begin
            csn[cmd_q.device] = 1'b0;
        end
    end

    always_ff @(posedge aximm) begin
        if (pop) begin
            cmd_q <= cmd_data;
            // Left-align the low xfer_len bits so they go out MSB first
            tx_sh <= cmd_data.mosi << (DW - int'(cmd_data.xfer_len));
            rx_sh <= '0;
        end else begin
            if (sample) begin
                rx_sh <= {rx_sh[DW-2:0], miso};
            end
            if (advance) begin
                tx_sh <= {tx_sh[DW-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge aximm) begin
        if (rst) begin
            state     <= ST_IDLE;
            tick      <= '0;
            bits_left <= '0;
            half      <= 1'b0;
            cpol_q    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state  <= ST_LEAD;
                        tick   <= cmd_data.guard;
                        cpol_q <= cmd_data.cpol;
                    end
                end
                ST_LEAD: begin
                    if (!tick_end) begin
                        tick <= tick - 1'b1;
                    end else if (cmd_q.xfer_len == '0) begin
                        state <= ST_TRAIL;
                        tick  <= cmd_q.guard;
                    end else begin
                        state     <= ST_SHIFT;
                        tick      <= cmd_q.sclk_div;
                        bits_left <= cmd_q.xfer_len;
                        half      <= 1'b0;
                    end
                end
                ST_SHIFT: begin
                    if (!tick_end) begin
                        tick <= tick - 1'b1;
                    end else begin
                        half <= !half;
                        tick <= cmd_q.sclk_div;
                        if (half) begin
                            bits_left <= bits_left - 1'b1;
                            if (bits_left == 6'd1) begin
                                state <= ST_TRAIL;
                                tick  <= cmd_q.guard;
                            end
                        end
                    end
                end
                ST_TRAIL: begin
                    if (tick_end) begin
                        state <= ST_DELIVER;
                    end else begin
                        tick <= tick - 1'b1;
                    end
                end
                // Hold here with csn released until the MISO queue has room
                ST_DELIVER: begin
                    if (miso_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/spi_master_top.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_master_top import spi_pkg::*; (
    input  logic                        aximm,
    input  logic                        rst,
    input  logic                        reg_req,
    input  logic                        reg_we,
    input  logic [`SPI_ADDR_W-1:0]      reg_addr,
    input  logic [`SPI_DATA_W-1:0]      reg_wdata,
    output logic                        reg_ack,
    output logic [`SPI_DATA_W-1:0]      reg_rdata,
    output logic                        intr,
    output logic [`SPI_NUM_DEVICES-1:0] csn,
    output logic                        sclk,
    output logic                        mosi,
    input  logic                        miso
);
    // Register block to command queue
    logic  cmd_in_valid;
    logic  cmd_in_ready;
    cmd_t  cmd_in_data;
    // Command queue to engine
    logic  cmd_out_valid;
    logic  cmd_out_ready;
    cmd_t  cmd_out_data;
    // Engine to received-word queue
    logic  rx_in_valid;
    logic  rx_in_ready;
    word_t rx_in_data;
    // Received-word queue to register block
    logic  rx_out_valid;
    logic  rx_out_ready;
    word_t rx_out_data;
    logic  enable;
    logic  busy;
    logic  done;

    spi_csr spi_csr_inst (
        .aximm(aximm), .rst(rst),
        .reg_req(reg_req), .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .reg_ack(reg_ack), .reg_rdata(reg_rdata),
        .cmd_valid(cmd_in_valid), .cmd_ready(cmd_in_ready), .cmd_data(cmd_in_data),
        .miso_valid(rx_out_valid), .miso_ready(rx_out_ready), .miso_data(rx_out_data),
        .enable(enable), .busy(busy), .done(done), .intr(intr)
    );

    stream_fifo #(.payload_t(cmd_t), .DEPTH(`SPI_CMD_DEPTH)) cmd_fifo_inst (
        .aximm(aximm), .rst(rst),
        .in_valid(cmd_in_valid), .in_ready(cmd_in_ready), .in_data(cmd_in_data),
        .out_valid(cmd_out_valid), .out_ready(cmd_out_ready), .out_data(cmd_out_data)
    );

    stream_fifo #(.payload_t(word_t), .DEPTH(`SPI_MISO_DEPTH)) miso_fifo_inst (
        .aximm(aximm), .rst(rst),
        .in_valid(rx_in_valid), .in_ready(rx_in_ready), .in_data(rx_in_data),
        .out_valid(rx_out_valid), .out_ready(rx_out_ready), .out_data(rx_out_data)
    );

    spi_engine spi_engine_inst (
        .aximm(aximm), .rst(rst), .enable(enable),
        .cmd_valid(cmd_out_valid), .cmd_ready(cmd_out_ready), .cmd_data(cmd_out_data),
        .miso_valid(rx_in_valid), .miso_ready(rx_in_ready), .miso_data(rx_in_data),
        .busy(busy), .done(done),
        .csn(csn), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

endmodule

// File: testbench/spi_master_properties.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_master_properties (
    input logic                        aximm,
    input logic                        rst,
    input logic                        reg_req,
    input logic                        reg_we,
    input logic [`SPI_ADDR_W-1:0]      reg_addr,
    input logic                        reg_ack,
    input logic                        intr,
    input logic [`SPI_NUM_DEVICES-1:0] csn,
    input logic                        sclk
);
    int assert_failures = 0;

    ack_needs_req: assert property (@(posedge aximm) disable iff (rst)
        $rose(reg_ack) |-> $past(reg_req))
        else begin assert_failures++; $error("reg_ack rose without reg_req"); end

    // Never two devices selected at once
    single_csn: assert property (@(posedge aximm) disable iff (rst) $onehot0(~csn))
        else begin assert_failures++; $error("more than one csn line low"); end

    sclk_quiet: assert property (@(posedge aximm) disable iff (rst)
        &csn |-> $stable(sclk))
        else begin assert_failures++; $error("sclk toggled with all csn lines high"); end

    intr_cleared: assert property (@(posedge aximm) disable iff (rst)
        reg_req && reg_we && !reg_ack && reg_addr == `REG_INTRACK |=> !intr)
        else begin assert_failures++; $error("intr still high after acknowledge"); end

endmodule

bind spi_master_top spi_master_properties spi_master_properties_inst (
    .aximm(aximm), .rst(rst), .reg_req(reg_req), .reg_we(reg_we), .reg_addr(reg_addr),
    .reg_ack(reg_ack), .intr(intr), .csn(csn), .sclk(sclk)
);

// File: testbench/spi_master_tb.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_master_tb;
    localparam int MAX_DIV     = 3;
    localparam int MAX_GUARD   = 3;
    // Worst-case cycles for one transfer with the profiles used here plus deliver and bus slack
    localparam int WORST_XFER  = 2 * (MAX_GUARD + 1) + 2 * 32 * (MAX_DIV + 1) + 16;
    localparam int WATCHDOG_NS = 200 * WORST_XFER * 10;
    localparam int BUS_LIMIT   = 8;
    localparam int POLL_LIMIT  = 4 * WORST_XFER;

    logic                        aximm;
    logic                        rst;
    logic                        reg_req;
    logic                        reg_we;
    logic [`SPI_ADDR_W-1:0]      reg_addr;
    logic [`SPI_DATA_W-1:0]      reg_wdata;
    logic                        reg_ack;
    logic [`SPI_DATA_W-1:0]      reg_rdata;
    logic                        intr;
    logic [`SPI_NUM_DEVICES-1:0] csn;
    logic                        sclk;
    logic                        mosi;
    logic                        miso;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'hc290d2a8;
    int          exp_dev [$];
    int          exp_len [$];
    int          exp_mode [$];
    logic [31:0] exp_sent [$];
    logic [31:0] exp_word [$];

    // Transfer monitor state
    int          cur_dev = 0;
    int          cur_len = 0;
    int          cur_mode = 0;
    int          toggles = 0;
    logic        csn_active_q = 1'b0;
    logic        sclk_q = 1'b0;
    logic        sclk_lead;
    logic [31:0] rx_model = '0;
    logic [3:0]  csn_exp;

    // Loopback so each received word mirrors the word sent
    assign miso = mosi;

    spi_master_top spi_master_top_inst (.*);

    initial begin
        aximm = 1'b0;
        forever #5 aximm = ~aximm;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] len_mask(input int len);
        return (len >= 32) ? 32'hffff_ffff : (32'h1 << len) - 32'h1;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Four-phase access that starts and returns on a falling edge
    task automatic bus_access(input logic we, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited    = 0;
        reg_req   = 1'b1;
        reg_we    = we;
        reg_addr  = addr;
        reg_wdata = wdata;
        do begin
            @(negedge aximm);
            waited++;
        end while (!reg_ack && waited < BUS_LIMIT);
        if (!reg_ack) begin
            errors++;
            $display("bus timeout: no ack for access to address %h", addr);
        end
        rdata   = reg_rdata;
        reg_req = 1'b0;
        waited  = 0;
        do begin
            @(negedge aximm);
            waited++;
        end while (reg_ack && waited < BUS_LIMIT);
        if (reg_ack) begin
            errors++;
            $display("bus timeout: ack stayed high after the request dropped");
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic expect_reg(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        read_reg(addr, rd);
        expect_equal(name, rd, exp);
    endtask

    // Program one profile with random timing and trigger a transfer through it
    task automatic issue_transfer(input int prof, input int mode);
        int          len;
        int          dev;
        logic [31:0] word;
        int          base;
        len  = int'(lcg_next() % 32) + 1;
        dev  = int'(lcg_next() % 4);
        word = lcg_next();
        base = `REG_PROFBASE + prof * `REG_PROFSTRIDE;
        write_reg(8'(base + `REG_PROF_POLPHA), 32'(mode));
        write_reg(8'(base + `REG_PROF_SCLKDIV), lcg_next() % (MAX_DIV + 1));
        write_reg(8'(base + `REG_PROF_XFERLEN), 32'(len));
        write_reg(8'(base + `REG_PROF_GUARD), lcg_next() % (MAX_GUARD + 1));
        write_reg(`REG_DEVSEL, 32'(dev));
        write_reg(`REG_PROFSEL, 32'(prof));
        write_reg(`REG_MOSI, word);
        exp_dev.push_back(dev);
        exp_len.push_back(len);
        exp_mode.push_back(mode);
        exp_sent.push_back(word & len_mask(len));
        exp_word.push_back(word & len_mask(len));
        write_reg(`REG_TRIGGER, 32'h0);
    endtask

    task automatic wait_completions(input int n);
        logic [31:0] cnt;
        int          polls;
        polls = 0;
        read_reg(`REG_CMPLCNT, cnt);
        while (cnt < 32'(n) && polls < POLL_LIMIT) begin
            read_reg(`REG_CMPLCNT, cnt);
            polls++;
        end
        if (cnt < 32'(n)) begin
            errors++;
            $display("completion count stuck at %0d while waiting for %0d", cnt, n);
        end
    endtask

    task automatic drain_words(input int n);
        logic [31:0] rd;
        repeat (n) begin
            read_reg(`REG_MISO, rd);
            expect_equal("miso_word", rd, exp_word.pop_front());
        end
    endtask

    // Tracks each csn window, checks the selected line and the sclk idle level,
    // counts sclk edges and captures mosi on the edge a device in that mode uses
    always @(negedge aximm) begin
        if (!rst) begin
            if (csn != '1) begin
                if (!csn_active_q) begin
                    toggles  = 0;
                    rx_model = '0;
                    if (exp_dev.size() == 0) begin
                        errors++;
                        $display("csn went low with no transfer pending");
                    end else begin
                        cur_dev  = exp_dev.pop_front();
                        cur_len  = exp_len.pop_front();
                        cur_mode = exp_mode.pop_front();
                    end
                    expect_equal("sclk_idle", 32'(sclk), 32'(cur_mode / 2));
                end else if (sclk != sclk_q) begin
                    toggles++;
                    sclk_lead = (sclk_q == 1'(cur_mode / 2));
                    // Even modes capture on the leading edge, odd modes on the trailing edge
                    if (sclk_lead != 1'(cur_mode % 2)) begin
                        rx_model = {rx_model[30:0], mosi};
                    end
                end
                csn_exp = ~(4'b1 << cur_dev);
                expect_equal("csn", 32'(csn), 32'(csn_exp));
            end else if (csn_active_q) begin
                expect_equal("sclk_edges", 32'(toggles), 32'(2 * cur_len));
                expect_equal("mosi", rx_model, exp_sent.pop_front());
            end
            csn_active_q = (csn != '1);
            sclk_q       = sclk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run exceeded %0d ns without finishing", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        int          base;
        int          total;
        rst       = 1'b1;
        reg_req   = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (5) @(negedge aximm);
        rst = 1'b0;

        // Reset values
        expect_reg("id", `REG_ID, `SPI_MAGIC);
        expect_reg("ctrl", `REG_CTRL, 32'h0);
        for (int p = 0; p < `SPI_NUM_PROFILES; p++) begin
            base = `REG_PROFBASE + p * `REG_PROFSTRIDE;
            expect_reg("prof_polpha", 8'(base + `REG_PROF_POLPHA), 32'h0);
            expect_reg("prof_sclkdiv", 8'(base + `REG_PROF_SCLKDIV), 32'hff);
            expect_reg("prof_xferlen", 8'(base + `REG_PROF_XFERLEN), 32'h8);
            expect_reg("prof_guard", 8'(base + `REG_PROF_GUARD), 32'hff);
        end
        expect_reg("miso_empty", `REG_MISO, 32'hffff_ffff);

        // Readback masked to field widths
        for (int p = 0; p < `SPI_NUM_PROFILES; p++) begin
            for (int f = 0; f < 4; f++) begin
                base = `REG_PROFBASE + p * `REG_PROFSTRIDE + f;
                rd   = lcg_next();
                write_reg(8'(base), rd);
                expect_reg("prof_field", 8'(base),
                           rd & ((f == 0) ? 32'h3 : (f == 2) ? 32'h3f : 32'hff));
            end
        end
        rd = lcg_next();
        write_reg(`REG_DEVSEL, rd);
        expect_reg("devsel", `REG_DEVSEL, rd & 32'h3);
        rd = lcg_next();
        write_reg(`REG_PROFSEL, rd);
        expect_reg("profsel", `REG_PROFSEL, rd & 32'h3);
        rd = lcg_next();
        write_reg(`REG_CMDID, rd);
        expect_reg("cmdid", `REG_CMDID, rd & 32'hffff);

        // Loopback in batches of three that cover all four modes
        write_reg(`REG_CTRL, 32'h1);
        total = 0;
        for (int b = 0; b < 8; b++) begin
            for (int k = 0; k < 3; k++) begin
                issue_transfer((b * 3 + k) % 4, (b * 3 + k) % 4);
            end
            total += 3;
            wait_completions(total);
            drain_words(3);
        end
        expect_equal("pending_transfers", 32'(exp_dev.size()), 32'h0);

        // Pending interrupt stays masked until enabled and then is acknowledged
        expect_equal("intr", 32'(intr), 32'h0);
        write_reg(`REG_CTRL, 32'h21);
        expect_equal("intr", 32'(intr), 32'h1);
        write_reg(`REG_INTRACK, 32'h0);
        expect_equal("intr", 32'(intr), 32'h0);
        expect_reg("cmplcnt", `REG_CMPLCNT, 32'(total));
        write_reg(`REG_CMPLCNT, 32'h0);
        expect_reg("cmplcnt", `REG_CMPLCNT, 32'h0);

        // Engine stopped so four commands fill the queue and the fifth is dropped
        write_reg(`REG_CTRL, 32'h8);
        write_reg(`REG_CMDID, 32'h1230);
        for (int k = 0; k < 4; k++) begin
            issue_transfer(k, k);
            expect_reg("cmdid", `REG_CMDID, 32'h1231 + 32'(k));
        end
        expect_reg("trigger_status", `REG_TRIGGER, 32'h0);
        write_reg(`REG_TRIGGER, 32'h0);
        expect_reg("cmdid", `REG_CMDID, 32'h1234);
        expect_reg("trigger_status", `REG_TRIGGER, 32'h2);
        expect_reg("ctrl", `REG_CTRL, 32'ha);
        write_reg(`REG_CTRL, 32'ha);
        expect_reg("ctrl", `REG_CTRL, 32'h8);
        expect_reg("trigger_status", `REG_TRIGGER, 32'h0);

        write_reg(`REG_CTRL, 32'h1);
        wait_completions(4);
        drain_words(4);
        expect_equal("pending_transfers", 32'(exp_dev.size()), 32'h0);

        errors += spi_master_top_inst.spi_master_properties_inst.assert_failures;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/spi_pkg.sv
design/stream_fifo.sv
spi_csr/spi_csr.sv
spi_engine/spi_engine.sv
design/spi_master_top.sv
testbench/spi_master_properties.sv
testbench/spi_master_tb.sv

// File: Makefile
TOOL      := verilator
TOP       := spi_master_tb
FILELIST  := files.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
